/* verilog.f */
+incdir+hw
hw/madgwick_pkg.sv
hw/gyro_quat_derivative.sv
hw/quat_integrator.sv
hw/fixed_isqrt.sv
hw/quat_normaliser.sv
hw/attitude_controller.sv
hw/madgwick_top.sv
testbench/madgwick_tb.sv

/* testbench/madgwick_tb.sv */
// testbench for the gyro attitude update: reference model, compare tasks, directed tests
`default_nettype none

`include "madgwick_consts.svh"

module madgwick_tb;
    import madgwick_pkg::*;

    localparam int NUM_TESTS = 7;
    localparam int WATCHDOG_CYCLES = NUM_TESTS * 2000;
    localparam int STEP_SHIFT = `DELTA_T_FRACT_WIDTH + `GYRO_FRACT_WIDTH;
    localparam int RATE_LIMIT = 4 << `GYRO_FRACT_WIDTH;
    localparam q_elem_t Q_ONE = q_elem_t'(1 << `Q_FRACT_WIDTH);

    logic clk;
    logic rst_n;
    logic valid_in;
    logic ready_in;
    gyro_t w_x;
    gyro_t w_y;
    gyro_t w_z;
    logic valid_out;
    logic ready_out;
    q_elem_t q_w;
    q_elem_t q_x;
    q_elem_t q_y;
    q_elem_t q_z;

    int errors;
    int checks;
    int tests_run;
    logic [31:0] rng;

    // reference state quaternion
    q_elem_t m_w;
    q_elem_t m_x;
    q_elem_t m_y;
    q_elem_t m_z;

    madgwick_top dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .valid_in  (valid_in),
        .ready_in  (ready_in),
        .w_x       (w_x),
        .w_y       (w_y),
        .w_z       (w_z),
        .valid_out (valid_out),
        .ready_out (ready_out),
        .q_w       (q_w),
        .q_x       (q_x),
        .q_y       (q_y),
        .q_z       (q_z)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TEST FAIL");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // uniform over about +-4 rad/s
    function automatic gyro_t rate_from(input logic [31:0] r);
        return gyro_t'(int'(r[14:0]) - RATE_LIMIT);
    endfunction

    // largest r with r*r <= n, set bit by bit from the top
    function automatic longint isqrt_floor(input longint n);
        longint r;
        longint cand;
        r = 0;
        for (int b = 17; b >= 0; b--) begin
            cand = r | (longint'(1) << b);
            if (cand * cand <= n) begin
                r = cand;
            end
        end
        return r;
    endfunction

    function automatic q_elem_t integrate_elem(input q_elem_t q, input longint dq);
        longint acc;
        acc = dq * `DELTA_T_RAW + (longint'(q) <<< STEP_SHIFT);
        acc = (acc + (longint'(1) <<< (STEP_SHIFT - 1))) >>> STEP_SHIFT;
        return q_elem_t'(acc);
    endfunction

    // truncating |v| / mag, sign put back afterwards
    function automatic q_elem_t scale_elem(input q_elem_t v, input longint mag);
        longint a;
        q_elem_t r;
        a = (v < 0) ? -longint'(v) : longint'(v);
        r = q_elem_t'((a <<< `Q_FRACT_WIDTH) / mag);
        return (v < 0) ? -r : r;
    endfunction

    task automatic model_step(input gyro_t wx, input gyro_t wy, input gyro_t wz);
        longint dw;
        longint dx;
        longint dy;
        longint dz;
        q_elem_t iw;
        q_elem_t ix;
        q_elem_t iy;
        q_elem_t iz;
        longint mag;
        // q times the pure rate quaternion (0, w)
        dw = -(longint'(m_x) * wx + longint'(m_y) * wy + longint'(m_z) * wz);
        dx = longint'(m_w) * wx + longint'(m_y) * wz - longint'(m_z) * wy;
        dy = longint'(m_w) * wy + longint'(m_z) * wx - longint'(m_x) * wz;
        dz = longint'(m_w) * wz + longint'(m_x) * wy - longint'(m_y) * wx;
        iw = integrate_elem(m_w, dw >>> 1);
        ix = integrate_elem(m_x, dx >>> 1);
        iy = integrate_elem(m_y, dy >>> 1);
        iz = integrate_elem(m_z, dz >>> 1);
        mag = isqrt_floor(longint'(iw) * iw + longint'(ix) * ix
                          + longint'(iy) * iy + longint'(iz) * iz);
        if (mag == 0) begin
            m_w = Q_ONE;
            m_x = '0;
            m_y = '0;
            m_z = '0;
        end else begin
            m_w = scale_elem(iw, mag);
            m_x = scale_elem(ix, mag);
            m_y = scale_elem(iy, mag);
            m_z = scale_elem(iz, mag);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // compare tasks and handshake helpers
    //////////////////////////////////////////////////////////////////////

    task automatic check_quat(
        input string what,
        input q_elem_t gw, input q_elem_t gx, input q_elem_t gy, input q_elem_t gz,
        input q_elem_t ew, input q_elem_t ex, input q_elem_t ey, input q_elem_t ez
    );
        checks++;
        if (gw !== ew || gx !== ex || gy !== ey || gz !== ez) begin
            errors++;
            $display("[FAIL] %0t: %s: got (%0d %0d %0d %0d) expected (%0d %0d %0d %0d)",
                     $time, what, gw, gx, gy, gz, ew, ex, ey, ez);
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t: %s: got %b expected %b", $time, what, got, exp);
        end
    endtask

    // called just after a rising edge; returns at the same phase
    task automatic send_sample(input gyro_t wx, input gyro_t wy, input gyro_t wz);
        valid_in = 1'b1;
        w_x = wx;
        w_y = wy;
        w_z = wz;
        while (!ready_in) begin
            @(posedge clk);
            #2;
        end
        @(posedge clk);
        #2;
        valid_in = 1'b0;
    endtask

    task automatic wait_result(output q_elem_t rw, output q_elem_t rx,
                               output q_elem_t ry, output q_elem_t rz);
        while (!valid_out) begin
            @(posedge clk);
            #2;
        end
        rw = q_w;
        rx = q_x;
        ry = q_y;
        rz = q_z;
    endtask

    task automatic accept_result();
        ready_out = 1'b1;
        @(posedge clk);
        #2;
        ready_out = 1'b0;
        check_flag("valid_out after transfer", valid_out, 1'b0);
        check_flag("ready_in after transfer", ready_in, 1'b1);
    endtask

    task automatic run_sample(input string what, input gyro_t wx, input gyro_t wy,
                              input gyro_t wz, output q_elem_t rw, output q_elem_t rx,
                              output q_elem_t ry, output q_elem_t rz);
        model_step(wx, wy, wz);
        send_sample(wx, wy, wz);
        wait_result(rw, rx, ry, rz);
        check_quat(what, rw, rx, ry, rz, m_w, m_x, m_y, m_z);
        accept_result();
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("[%0t] %s: ok", $time, name);
        end else begin
            $display("[%0t] %s: %0d errors", $time, name, errors - errors_before);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////////////////////////

    task automatic test_reset();
        int e0;
        e0 = errors;
        check_flag("valid_out after reset", valid_out, 1'b0);
        check_flag("ready_in right after reset", ready_in, 1'b0);
        check_quat("outputs after reset", q_w, q_x, q_y, q_z, Q_ONE, '0, '0, '0);
        @(posedge clk);
        #2;
        check_flag("ready_in one clock after reset", ready_in, 1'b1);
        report_test("reset state", e0);
    endtask

    task automatic test_zero_rates();
        int e0;
        q_elem_t rw;
        q_elem_t rx;
        q_elem_t ry;
        q_elem_t rz;
        e0 = errors;
        run_sample("zero rates", '0, '0, '0, rw, rx, ry, rz);
        check_quat("zero rates keep identity", rw, rx, ry, rz, Q_ONE, '0, '0, '0);
        report_test("zero rates", e0);
    endtask

    task automatic test_single_axis(input int axis);
        int e0;
        string name;
        gyro_t wx;
        gyro_t wy;
        gyro_t wz;
        q_elem_t rw;
        q_elem_t rx;
        q_elem_t ry;
        q_elem_t rz;
        e0 = errors;
        wx = '0;
        wy = '0;
        wz = '0;
        // 2.0, -1.5 and 3.25 rad/s
        case (axis)
            0: begin
                wx = gyro_t'(8192);
                name = "single axis x";
            end
            1: begin
                wy = gyro_t'(-6144);
                name = "single axis y";
            end
            default: begin
                wz = gyro_t'(13312);
                name = "single axis z";
            end
        endcase
        run_sample(name, wx, wy, wz, rw, rx, ry, rz);
        report_test(name, e0);
    endtask

    task automatic test_chained();
        int e0;
        gyro_t wx;
        gyro_t wy;
        gyro_t wz;
        q_elem_t rw;
        q_elem_t rx;
        q_elem_t ry;
        q_elem_t rz;
        e0 = errors;
        for (int i = 0; i < 20; i++) begin
            rng = xorshift32(rng);
            wx = rate_from(rng);
            rng = xorshift32(rng);
            wy = rate_from(rng);
            rng = xorshift32(rng);
            wz = rate_from(rng);
            run_sample($sformatf("chained sample %0d", i), wx, wy, wz, rw, rx, ry, rz);
        end
        report_test("chained random samples", e0);
    endtask

    task automatic test_back_pressure();
        int e0;
        int hold;
        gyro_t wx;
        gyro_t wy;
        gyro_t wz;
        q_elem_t rw;
        q_elem_t rx;
        q_elem_t ry;
        q_elem_t rz;
        e0 = errors;
        rng = xorshift32(rng);
        hold = 3 + int'(rng[2:0]);
        rng = xorshift32(rng);
        wx = rate_from(rng);
        rng = xorshift32(rng);
        wy = rate_from(rng);
        rng = xorshift32(rng);
        wz = rate_from(rng);
        model_step(wx, wy, wz);
        send_sample(wx, wy, wz);
        wait_result(rw, rx, ry, rz);
        check_quat("result before stall", rw, rx, ry, rz, m_w, m_x, m_y, m_z);
        for (int i = 0; i < hold; i++) begin
            // stray sample offered mid-stall, must be dropped
            valid_in = (i == 1);
            w_x = gyro_t'(12000);
            w_y = gyro_t'(-12000);
            w_z = gyro_t'(5000);
            @(posedge clk);
            #2;
            check_quat("outputs during stall", q_w, q_x, q_y, q_z, rw, rx, ry, rz);
            check_flag("valid_out during stall", valid_out, 1'b1);
            check_flag("ready_in during stall", ready_in, 1'b0);
        end
        valid_in = 1'b0;
        accept_result();
        rng = xorshift32(rng);
        wx = rate_from(rng);
        run_sample("sample after stall", wx, wy, wz, rw, rx, ry, rz);
        report_test("back-pressure", e0);
    endtask

    initial begin
        errors = 0;
        checks = 0;
        tests_run = 0;
        rng = 32'h12cc29b4;
        m_w = Q_ONE;
        m_x = '0;
        m_y = '0;
        m_z = '0;
        rst_n = 1'b0;
        valid_in = 1'b0;
        ready_out = 1'b0;
        w_x = '0;
        w_y = '0;
        w_z = '0;
        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;

        test_reset();
        test_zero_rates();
        test_single_axis(0);
        test_single_axis(1);
        test_single_axis(2);
        test_chained();
        test_back_pressure();

        $display("tests run: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* hw/madgwick_top.sv */
// top level of the gyro attitude update, unit instances and interconnect
`default_nettype none

module madgwick_top (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   valid_in,
    output logic                        ready_in,
    input  wire madgwick_pkg::gyro_t    w_x,
    input  wire madgwick_pkg::gyro_t    w_y,
    input  wire madgwick_pkg::gyro_t    w_z,
    output logic                        valid_out,
    input  wire logic                   ready_out,
    output madgwick_pkg::q_elem_t       q_w,
    output madgwick_pkg::q_elem_t       q_x,
    output madgwick_pkg::q_elem_t       q_y,
    output madgwick_pkg::q_elem_t       q_z
);
    logic deriv_start, integ_start, norm_start;
    logic deriv_done, integ_done, norm_done;
    madgwick_pkg::gyro_t gyro_x, gyro_y, gyro_z;
    madgwick_pkg::q_elem_t state_w, state_x, state_y, state_z;
    madgwick_pkg::q_dot_t dq_w, dq_x, dq_y, dq_z;
    madgwick_pkg::q_elem_t qi_w, qi_x, qi_y, qi_z;
    madgwick_pkg::q_elem_t qn_w, qn_x, qn_y, qn_z;

    attitude_controller u_ctrl (
        .clk(clk), .rst_n(rst_n),
        .valid_in(valid_in), .ready_in(ready_in),
        .w_x(w_x), .w_y(w_y), .w_z(w_z),
        .valid_out(valid_out), .ready_out(ready_out),
        .q_w(q_w), .q_x(q_x), .q_y(q_y), .q_z(q_z),
        .deriv_start(deriv_start), .integ_start(integ_start), .norm_start(norm_start),
        .deriv_done(deriv_done), .integ_done(integ_done), .norm_done(norm_done),
        .gyro_x(gyro_x), .gyro_y(gyro_y), .gyro_z(gyro_z),
        .state_w(state_w), .state_x(state_x), .state_y(state_y), .state_z(state_z),
        .qn_w(qn_w), .qn_x(qn_x), .qn_y(qn_y), .qn_z(qn_z)
    );

    gyro_quat_derivative u_deriv (
        .clk(clk), .rst_n(rst_n), .start(deriv_start),
        .q_w(state_w), .q_x(state_x), .q_y(state_y), .q_z(state_z),
        .w_x(gyro_x), .w_y(gyro_y), .w_z(gyro_z),
        .dq_w(dq_w), .dq_x(dq_x), .dq_y(dq_y), .dq_z(dq_z),
        .done(deriv_done)
    );

    quat_integrator u_integ (
        .clk(clk), .rst_n(rst_n), .start(integ_start),
        .q_w(state_w), .q_x(state_x), .q_y(state_y), .q_z(state_z),
        .dq_w(dq_w), .dq_x(dq_x), .dq_y(dq_y), .dq_z(dq_z),
        .qi_w(qi_w), .qi_x(qi_x), .qi_y(qi_y), .qi_z(qi_z),
        .done(integ_done)
    );

    quat_normaliser u_norm (
        .clk(clk), .rst_n(rst_n), .start(norm_start),
        .q_w(qi_w), .q_x(qi_x), .q_y(qi_y), .q_z(qi_z),
        .qn_w(qn_w), .qn_x(qn_x), .qn_y(qn_y), .qn_z(qn_z),
        .done(norm_done)
    );

endmodule

`default_nettype wire

/* hw/attitude_controller.sv */
// filter state register, outside handshakes and sequencing of the datapath units
`default_nettype none

`include "madgwick_consts.svh"

module attitude_controller (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   valid_in,
    output logic                        ready_in,
    input  wire madgwick_pkg::gyro_t    w_x,
    input  wire madgwick_pkg::gyro_t    w_y,
    input  wire madgwick_pkg::gyro_t    w_z,
    output logic                        valid_out,
    input  wire logic                   ready_out,
    output madgwick_pkg::q_elem_t       q_w,
    output madgwick_pkg::q_elem_t       q_x,
    output madgwick_pkg::q_elem_t       q_y,
    output madgwick_pkg::q_elem_t       q_z,
    output logic                        deriv_start,
    output logic                        integ_start,
    output logic                        norm_start,
    input  wire logic                   deriv_done,
    input  wire logic                   integ_done,
    input  wire logic                   norm_done,
    output madgwick_pkg::gyro_t         gyro_x,
    output madgwick_pkg::gyro_t         gyro_y,
    output madgwick_pkg::gyro_t         gyro_z,
    output madgwick_pkg::q_elem_t       state_w,
    output madgwick_pkg::q_elem_t       state_x,
    output madgwick_pkg::q_elem_t       state_y,
    output madgwick_pkg::q_elem_t       state_z,
    input  wire madgwick_pkg::q_elem_t  qn_w,
    input  wire madgwick_pkg::q_elem_t  qn_x,
    input  wire madgwick_pkg::q_elem_t  qn_y,
    input  wire madgwick_pkg::q_elem_t  qn_z
);
    import madgwick_pkg::*;

    localparam q_elem_t Q_ONE = q_elem_t'(1 << `Q_FRACT_WIDTH);

    ctrl_state_t state;

    // filter state doubles as the output quaternion
    assign state_w = q_w;
    assign state_x = q_x;
    assign state_y = q_y;
    assign state_z = q_z;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= CTRL_IDLE;
            ready_in <= 1'b0;
            valid_out <= 1'b0;
            deriv_start <= 1'b0;
            integ_start <= 1'b0;
            norm_start <= 1'b0;
            q_w <= Q_ONE;
            q_x <= '0;
            q_y <= '0;
            q_z <= '0;
        end else begin
            deriv_start <= 1'b0;
            integ_start <= 1'b0;
            norm_start <= 1'b0;
            case (state)
                CTRL_IDLE: begin
                    ready_in <= !(valid_in && ready_in);
                    if (valid_in && ready_in) begin
                        deriv_start <= 1'b1;
                        state <= CTRL_DERIV;
                    end
                end
                CTRL_DERIV: if (deriv_done) begin
                    integ_start <= 1'b1;
                    state <= CTRL_INTEG;
                end
                CTRL_INTEG: if (integ_done) begin
                    norm_start <= 1'b1;
                    state <= CTRL_NORM;
                end
                CTRL_NORM: if (norm_done) begin
                    q_w <= qn_w;
                    q_x <= qn_x;
                    q_y <= qn_y;
                    q_z <= qn_z;
                    valid_out <= 1'b1;
                    state <= CTRL_OUTPUT;
                end
                default: if (ready_out) begin
                    valid_out <= 1'b0;
                    ready_in <= 1'b1;
                    state <= CTRL_IDLE;
                end
            endcase
        end
    end

    // sample capture on acceptance
    always_ff @(posedge clk) begin
        if (state == CTRL_IDLE && valid_in && ready_in) begin
            gyro_x <= w_x;
            gyro_y <= w_y;
            gyro_z <= w_z;
        end
    end

    a_out_hold: assert property (@(posedge clk) disable iff (!rst_n)
        valid_out && !ready_out |=> valid_out && $stable({q_w, q_x, q_y, q_z}));

endmodule

`default_nettype wire

/* hw/quat_normaliser.sv */
// quaternion renormalisation by square root and serial restoring division
`default_nettype none

`include "madgwick_consts.svh"

module quat_normaliser (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   start,
    input  wire madgwick_pkg::q_elem_t  q_w,
    input  wire madgwick_pkg::q_elem_t  q_x,
    input  wire madgwick_pkg::q_elem_t  q_y,
    input  wire madgwick_pkg::q_elem_t  q_z,
    output madgwick_pkg::q_elem_t       qn_w,
    output madgwick_pkg::q_elem_t       qn_x,
    output madgwick_pkg::q_elem_t       qn_y,
    output madgwick_pkg::q_elem_t       qn_z,
    output logic                        done
);
    import madgwick_pkg::*;

    localparam int ROOT_W = (`Q_MAG_SQR_WIDTH + 1) / 2;
    localparam int NUM_W = `Q_WIDTH + `Q_FRACT_WIDTH;
    localparam int CNT_W = $clog2(NUM_W + 1);
    localparam q_elem_t Q_ONE = q_elem_t'(1 << `Q_FRACT_WIDTH);

    typedef enum logic [1:0] {N_IDLE, N_SQRT, N_LOAD, N_DIV} norm_state_t;

    norm_state_t nstate;
    mag_sqr_t sum_sqr;
    mag_sqr_t mag_sqr;
    logic sqrt_start;
    logic sqrt_done;
    logic [ROOT_W-1:0] mag;
    logic [1:0] idx;
    logic [CNT_W-1:0] count;
    q_elem_t sel_q;
    logic [`Q_WIDTH-1:0] sel_abs;
    logic neg;
    logic [NUM_W-1:0] num_sh;
    logic [NUM_W-1:0] quot;
    logic [NUM_W-1:0] quot_step;
    logic [ROOT_W-1:0] rem;
    logic [ROOT_W-1:0] rem_step;
    logic [ROOT_W:0] rem_shift;
    logic fits;
    q_elem_t result;

    function automatic mag_sqr_t square(q_elem_t v);
        logic signed [2*`Q_WIDTH-1:0] p;
        p = v * v;
        return mag_sqr_t'(p);
    endfunction

    always_comb begin
        sum_sqr = square(q_w) + square(q_x) + square(q_y) + square(q_z);
        case (idx)
            2'd0: sel_q = q_w;
            2'd1: sel_q = q_x;
            2'd2: sel_q = q_y;
            default: sel_q = q_z;
        endcase
        sel_abs = sel_q[`Q_WIDTH-1] ? -sel_q : sel_q;
        // one quotient bit per cycle
        rem_shift = {rem, num_sh[NUM_W-1]};
        fits = rem_shift >= {1'b0, mag};
        rem_step = fits ? rem_shift[ROOT_W-1:0] - mag : rem_shift[ROOT_W-1:0];
        quot_step = {quot[NUM_W-2:0], fits};
        result = neg ? -q_elem_t'(quot_step[`Q_WIDTH-1:0]) : q_elem_t'(quot_step[`Q_WIDTH-1:0]);
    end

    fixed_isqrt u_isqrt (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (sqrt_start),
        .radicand (mag_sqr),
        .root     (mag),
        .done     (sqrt_done)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            nstate <= N_IDLE;
            sqrt_start <= 1'b0;
            done <= 1'b0;
            idx <= '0;
            count <= '0;
        end else begin
            sqrt_start <= 1'b0;
            done <= 1'b0;
            case (nstate)
                N_IDLE: if (start) begin
                    sqrt_start <= 1'b1;
                    idx <= '0;
                    nstate <= N_SQRT;
                end
                N_SQRT: if (sqrt_done) begin
                    nstate <= (mag == '0) ? N_IDLE : N_LOAD;
                    done <= (mag == '0);
                end
                N_LOAD: begin
                    count <= CNT_W'(NUM_W);
                    nstate <= N_DIV;
                end
                default: begin
                    count <= count - 1'b1;
                    if (count == 1) begin
                        idx <= idx + 1'b1;
                        nstate <= (idx == 2'd3) ? N_IDLE : N_LOAD;
                        done <= (idx == 2'd3);
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (nstate == N_IDLE && start) begin
            mag_sqr <= sum_sqr;
        end
        // degenerate magnitude falls back to identity
        if (nstate == N_SQRT && sqrt_done && mag == '0) begin
            qn_w <= Q_ONE;
            qn_x <= '0;
            qn_y <= '0;
            qn_z <= '0;
        end
        if (nstate == N_LOAD) begin
            num_sh <= {sel_abs, {`Q_FRACT_WIDTH{1'b0}}};
            rem <= '0;
            quot <= '0;
            neg <= sel_q[`Q_WIDTH-1];
        end
        if (nstate == N_DIV) begin
            num_sh <= num_sh << 1;
            rem <= rem_step;
            quot <= quot_step;
            if (count == 1) begin
                case (idx)
                    2'd0: qn_w <= result;
                    2'd1: qn_x <= result;
                    2'd2: qn_y <= result;
                    default: qn_z <= result;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* hw/fixed_isqrt.sv */
// bit-serial restoring square root, one root bit per cycle
`default_nettype none

`include "madgwick_consts.svh"

module fixed_isqrt (
    input  wire logic                               clk,
    input  wire logic                               rst_n,
    input  wire logic                               start,
    input  wire madgwick_pkg::mag_sqr_t             radicand,
    output logic [(`Q_MAG_SQR_WIDTH+1)/2-1:0]       root,
    output logic                                    done
);
    import madgwick_pkg::*;

    localparam int ROOT_W = (`Q_MAG_SQR_WIDTH + 1) / 2;
    localparam int REM_W = ROOT_W + 3;
    localparam int CNT_W = $clog2(ROOT_W + 1);

    mag_sqr_t rad_sh;
    logic [REM_W-1:0] rem;
    logic [REM_W-1:0] rem_shift;
    logic [REM_W-1:0] trial;
    logic fits;
    logic busy;
    logic [CNT_W-1:0] count;

    // bring down two radicand bits, try 4*root + 1
    always_comb begin
        rem_shift = {rem[REM_W-3:0], rad_sh[`Q_MAG_SQR_WIDTH-1 -: 2]};
        trial = {1'b0, root, 2'b01};
        fits = rem_shift >= trial;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            count <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                count <= CNT_W'(ROOT_W);
            end else if (busy) begin
                count <= count - 1'b1;
                if (count == 1) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            rad_sh <= radicand;
            rem <= '0;
            root <= '0;
        end else if (busy) begin
            rad_sh <= rad_sh << 2;
            rem <= fits ? rem_shift - trial : rem_shift;
            root <= {root[ROOT_W-2:0], fits};
        end
    end

    // radicand is held by the normaliser until done
    a_root_floor: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> mag_sqr_t'(root) * mag_sqr_t'(root) <= radicand);

endmodule

`default_nettype wire

/* hw/quat_integrator.sv */
// one-step integration of the quaternion derivative with rounding to Q2.14
`default_nettype none

`include "madgwick_consts.svh"

module quat_integrator (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   start,
    input  wire madgwick_pkg::q_elem_t  q_w,
    input  wire madgwick_pkg::q_elem_t  q_x,
    input  wire madgwick_pkg::q_elem_t  q_y,
    input  wire madgwick_pkg::q_elem_t  q_z,
    input  wire madgwick_pkg::q_dot_t   dq_w,
    input  wire madgwick_pkg::q_dot_t   dq_x,
    input  wire madgwick_pkg::q_dot_t   dq_y,
    input  wire madgwick_pkg::q_dot_t   dq_z,
    output madgwick_pkg::q_elem_t       qi_w,
    output madgwick_pkg::q_elem_t       qi_x,
    output madgwick_pkg::q_elem_t       qi_y,
    output madgwick_pkg::q_elem_t       qi_z,
    output logic                        done
);
    import madgwick_pkg::*;

    // 42 fraction bits after the time-step product
    localparam int SUM_FRACT = `DELTA_T_FRACT_WIDTH + `Q_FRACT_WIDTH + `GYRO_FRACT_WIDTH;
    localparam int SHIFT = SUM_FRACT - `Q_FRACT_WIDTH;
    localparam int ACC_W = `Q_DOT_WIDTH + `DELTA_T_WIDTH + 2;
    localparam logic signed [`DELTA_T_WIDTH:0] DELTA_T = `DELTA_T_RAW;
    localparam logic signed [ACC_W-1:0] ROUND = ACC_W'(1) << (SHIFT - 1);

    function automatic q_elem_t integrate(q_elem_t q, q_dot_t dq);
        logic signed [ACC_W-1:0] state_term;
        logic signed [ACC_W-1:0] acc;
        state_term = q;
        state_term = state_term <<< SHIFT;
        acc = dq * DELTA_T + state_term + ROUND;
        acc = acc >>> SHIFT;
        return acc[`Q_WIDTH-1:0];
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done <= 1'b0;
        end else begin
            done <= start;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            qi_w <= integrate(q_w, dq_w);
            qi_x <= integrate(q_x, dq_x);
            qi_y <= integrate(q_y, dq_y);
            qi_z <= integrate(q_z, dq_z);
        end
    end

endmodule

`default_nettype wire

/* hw/gyro_quat_derivative.sv */
// quaternion derivative from gyro rates, one component per cycle on three multipliers
`default_nettype none

`include "madgwick_consts.svh"

module gyro_quat_derivative (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   start,
    input  wire madgwick_pkg::q_elem_t  q_w,
    input  wire madgwick_pkg::q_elem_t  q_x,
    input  wire madgwick_pkg::q_elem_t  q_y,
    input  wire madgwick_pkg::q_elem_t  q_z,
    input  wire madgwick_pkg::gyro_t    w_x,
    input  wire madgwick_pkg::gyro_t    w_y,
    input  wire madgwick_pkg::gyro_t    w_z,
    output madgwick_pkg::q_dot_t        dq_w,
    output madgwick_pkg::q_dot_t        dq_x,
    output madgwick_pkg::q_dot_t        dq_y,
    output madgwick_pkg::q_dot_t        dq_z,
    output logic                        done
);
    import madgwick_pkg::*;

    typedef enum logic [2:0] {D_IDLE, D_W, D_X, D_Y, D_Z} deriv_state_t;

    deriv_state_t dstate;
    q_elem_t op_q [3];
    gyro_t op_g [3];
    logic signed [`Q_WIDTH+`GYRO_WIDTH-1:0] prod [3];
    q_dot_t sum;

    // operand pairs of q (x) (0, w) for the current component
    always_comb begin
        case (dstate)
            D_W: begin
                op_q = '{q_x, q_y, q_z};
                op_g = '{w_x, w_y, w_z};
            end
            D_X: begin
                op_q = '{q_w, q_y, q_z};
                op_g = '{w_x, w_z, w_y};
            end
            D_Y: begin
                op_q = '{q_w, q_z, q_x};
                op_g = '{w_y, w_x, w_z};
            end
            default: begin
                op_q = '{q_w, q_x, q_y};
                op_g = '{w_z, w_y, w_x};
            end
        endcase
        for (int i = 0; i < 3; i++) begin
            prod[i] = op_q[i] * op_g[i];
        end
        // third product always subtracts, w negates all three
        if (dstate == D_W) begin
            sum = -prod[0] - prod[1] - prod[2];
        end else begin
            sum = prod[0] + prod[1] - prod[2];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dstate <= D_IDLE;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            case (dstate)
                D_IDLE: if (start) dstate <= D_W;
                D_W: dstate <= D_X;
                D_X: dstate <= D_Y;
                D_Y: dstate <= D_Z;
                default: begin
                    dstate <= D_IDLE;
                    done <= 1'b1;
                end
            endcase
        end
    end

    // halved sums, fraction stays at 26 bits
    always_ff @(posedge clk) begin
        case (dstate)
            D_W: dq_w <= sum >>> 1;
            D_X: dq_x <= sum >>> 1;
            D_Y: dq_y <= sum >>> 1;
            D_Z: dq_z <= sum >>> 1;
            default: ;
        endcase
    end

    // controller must wait for done before the next start
    a_no_start_busy: assert property (@(posedge clk) disable iff (!rst_n)
        start |-> dstate == D_IDLE);

endmodule

`default_nettype wire

/* hw/madgwick_pkg.sv */
// element types and controller state enumeration for the attitude filter
`default_nettype none

`include "madgwick_consts.svh"

package madgwick_pkg;

    typedef logic signed [`Q_WIDTH-1:0] q_elem_t;
    typedef logic signed [`GYRO_WIDTH-1:0] gyro_t;
    typedef logic signed [`Q_DOT_WIDTH-1:0] q_dot_t;
    typedef logic [`Q_MAG_SQR_WIDTH-1:0] mag_sqr_t;

    // sequence of one filter update
    typedef enum logic [2:0] {
        CTRL_IDLE,
        CTRL_DERIV,
        CTRL_INTEG,
        CTRL_NORM,
        CTRL_OUTPUT
    } ctrl_state_t;

endpackage

`default_nettype wire

/* hw/madgwick_consts.svh */
// widths, fraction positions and time step of the attitude datapath
`ifndef MADGWICK_CONSTS_SVH
`define MADGWICK_CONSTS_SVH

//////////////////////////////////////////////////////////////////////
// quaternion elements, Q2.14
//////////////////////////////////////////////////////////////////////
`define Q_WIDTH 16
`define Q_FRACT_WIDTH 14

// gyro rates in rad/s, Q4.12
`define GYRO_WIDTH 16
`define GYRO_FRACT_WIDTH 12

// derivative carries q and gyro fractions, 26 bits
`define Q_DOT_WIDTH 34

//////////////////////////////////////////////////////////////////////
// integration step
//////////////////////////////////////////////////////////////////////
`define DELTA_T_WIDTH 16
`define DELTA_T_FRACT_WIDTH 16
// 655 / 2^16, roughly 10 ms
`define DELTA_T_RAW 655

// sum of four squared elements, 28 fraction bits
`define Q_MAG_SQR_WIDTH 34

`endif
